// ==== Makefile ====
# Verilator build for the VIC-II timing front end

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_vic_timing
FILELIST  ?= vic_timing_top.f
OBJ_DIR   ?= obj_dir

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a $fatal in the testbench gives a nonzero exit status
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/clockgen.sv ====
module clockgen (
    input  logic                  sys_clockb,
    input  logic                  internal_rst,
    input  vic_timing_pkg::chip_t chip_sel,
    output logic                  rst,
    output vic_timing_pkg::chip_t chip,
    output logic                  dot_stb,
    output logic                  cycle_stb
);

    // stretched reset into the phase generator
    logic pre_rst;
    // phase generator has run one full cpu cycle
    logic locked;

    // stretch internal_rst, then sync the release to lock
    reset_stretcher u_reset_stretcher (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .locked       (locked),
        .pre_rst      (pre_rst),
        .rst          (rst)
    );

    // dot and cpu cycle strobes, plus the lock flag
    dot_phase_gen u_dot_phase_gen (
        .sys_clockb (sys_clockb),
        .pre_rst    (pre_rst),
        .dot_stb    (dot_stb),
        .cycle_stb  (cycle_stb),
        .locked     (locked)
    );

    // chip type picked at run time
    // tracks chip_sel for as long as rst is up, then stays put
    always_ff @(posedge sys_clockb) begin
        if (rst) begin
            chip <= chip_sel;
        end
    end

    // once out of reset for a full cycle the chip type must not move,
    // whatever chip_sel does
    a_chip_frozen : assert property (
        @(posedge sys_clockb) (!rst && !$past(rst)) |-> $stable(chip)
    );

endmodule

// ==== logic/dot_phase_gen.sv ====
`include "vic_timing_cfg.svh"

module dot_phase_gen (
    input  logic sys_clockb,
    input  logic pre_rst,
    output logic dot_stb,
    output logic cycle_stb,
    output logic locked
);

    // low phase bits that count clocks within one dot
    localparam int dot_bits = $clog2(`VIC_DOT_DIV);

    // last phase value of a cpu cycle, 31 for 4 x 8
    localparam vic_timing_pkg::dot_phase_t last_phase =
        vic_timing_pkg::dot_phase_t'(`VIC_DOT_DIV * `VIC_DOTS_PER_CYCLE - 1);

    vic_timing_pkg::dot_phase_t phase;

    // decoded before the register stage
    logic dot_end;
    logic cycle_end;

    // dot ends when the low bits are all ones
    assign dot_end   = (phase[dot_bits-1:0] == {dot_bits{1'b1}});
    // cycle end is always also a dot end
    assign cycle_end = (phase == last_phase);

    always_ff @(posedge sys_clockb) begin
        if (pre_rst) begin
            // phase held at zero, strobes quiet, lock lost
            phase     <= '0;
            dot_stb   <= 1'b0;
            cycle_stb <= 1'b0;
            locked    <= 1'b0;
        end else begin
            if (cycle_end) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
            dot_stb   <= dot_end;
            cycle_stb <= cycle_end;
            // sticky, first full cpu cycle stands in for pll lock
            if (cycle_end) begin
                locked <= 1'b1;
            end
        end
    end

    // cpu cycle strobe always lands on a dot boundary
    a_cycle_on_dot : assert property (
        @(posedge sys_clockb) cycle_stb |-> dot_stb
    );

    // dots are never back to back at a divider of 4
    a_dot_spacing : assert property (
        @(posedge sys_clockb) dot_stb |=> !dot_stb
    );

endmodule

// ==== logic/raster_counter.sv ====
module raster_counter (
    input  logic                          sys_clockb,
    input  logic                          rst,
    input  vic_timing_pkg::chip_t         chip,
    input  logic                          cycle_stb,
    output vic_timing_pkg::raster_cycle_t raster_cycle,
    output vic_timing_pkg::raster_line_t  raster_line,
    output logic                          frame_stb
);

    // geometry of the selected chip
    vic_timing_pkg::raster_cycle_t cycles_per_line;
    vic_timing_pkg::raster_line_t  lines_per_frame;

    // wrap points of the position counter
    logic line_end;
    logic frame_end;

    // line length and frame height per chip type
    always_comb begin
        case (chip)
            vic_timing_pkg::chip_6567r56a: begin
                cycles_per_line = 7'd64;
                lines_per_frame = 9'd262;
            end
            vic_timing_pkg::chip_6567r8: begin
                cycles_per_line = 7'd65;
                lines_per_frame = 9'd263;
            end
            vic_timing_pkg::chip_6569: begin
                cycles_per_line = 7'd63;
                lines_per_frame = 9'd312;
            end
            vic_timing_pkg::chip_6572: begin
                cycles_per_line = 7'd65;
                lines_per_frame = 9'd312;
            end
            default: begin
                // unknown code, fall back to pal
                cycles_per_line = 7'd63;
                lines_per_frame = 9'd312;
            end
        endcase
    end

    assign line_end  = (raster_cycle == cycles_per_line - 7'd1);
    // last cycle of the last line
    assign frame_end = line_end && (raster_line == lines_per_frame - 9'd1);

    // position moves only on cpu cycle strobes
    always_ff @(posedge sys_clockb) begin
        if (rst) begin
            raster_cycle <= '0;
            raster_line  <= '0;
            frame_stb    <= 1'b0;
        end else begin
            frame_stb <= 1'b0;
            if (cycle_stb) begin
                if (line_end) begin
                    raster_cycle <= '0;
                    if (frame_end) begin
                        raster_line <= '0;
                        // high in the first cycle at line 0, cycle 0
                        frame_stb   <= 1'b1;
                    end else begin
                        raster_line <= raster_line + 9'd1;
                    end
                end else begin
                    raster_cycle <= raster_cycle + 7'd1;
                end
            end
        end
    end

    // no chip has more than 65 cycles per line
    a_cycle_range : assert property (
        @(posedge sys_clockb) disable iff (rst) raster_cycle < 7'd65
    );

    // no chip has more than 312 lines per frame
    a_line_range : assert property (
        @(posedge sys_clockb) disable iff (rst) raster_line < 9'd312
    );

endmodule

// ==== logic/reset_stretcher.sv ====
`include "vic_timing_cfg.svh"

module reset_stretcher (
    input  logic sys_clockb,
    input  logic internal_rst,
    input  logic locked,
    output logic pre_rst,
    output logic rst
);

    // stretch counter, cleared by internal_rst
    logic [`VIC_RST_STRETCH_BITS-1:0] cnt;

    // two flop synchronizer, sync[1] is the released reset
    logic [1:0] sync;

    // pre_rst goes high with internal_rst and holds until the
    // counter reaches all ones
    always_ff @(posedge sys_clockb) begin
        if (internal_rst) begin
            cnt     <= '0;
            pre_rst <= 1'b1;
        end else if (pre_rst) begin
            // release on the last count, counter stops there
            if (cnt == '1) begin
                pre_rst <= 1'b0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // zeros shift in once the phase generator reports lock
    // any loss of lock snaps both flops back to one
    always_ff @(posedge sys_clockb) begin
        if (internal_rst || !locked) begin
            sync <= 2'b11;
        end else begin
            sync <= {sync[0], 1'b0};
        end
    end

    assign rst = sync[1];

    // the released reset can only drop after the stretch is over
    // and the phase generator has come back through lock
    a_rst_covers_pre_rst : assert property (
        @(posedge sys_clockb) pre_rst |-> rst
    );

endmodule

// ==== logic/vic_timing_cfg.svh ====
`ifndef VIC_TIMING_CFG_SVH
`define VIC_TIMING_CFG_SVH

// width of the reset stretch counter
// 4 bits holds pre_rst for 16 cycles after internal_rst drops
`define VIC_RST_STRETCH_BITS 4

// sys_clockb cycles per dot, a power of two
`define VIC_DOT_DIV 4

// dots per cpu cycle
// VIC_DOT_DIV * VIC_DOTS_PER_CYCLE has to fit dot_phase_t
`define VIC_DOTS_PER_CYCLE 8

`endif

// ==== logic/vic_timing_pkg.sv ====
package vic_timing_pkg;

    // chip types this front end can mimic
    // geometry per type lives in raster_counter
    typedef enum logic [1:0] {
        // old ntsc, 64 cycles x 262 lines
        chip_6567r56a = 2'd0,
        // ntsc, 65 cycles x 263 lines
        chip_6567r8   = 2'd1,
        // pal, 63 cycles x 312 lines
        chip_6569     = 2'd2,
        // pal-n, 65 cycles x 312 lines
        chip_6572     = 2'd3
    } chip_t;

    // cpu cycle index within one raster line
    // widest line is 65 cycles, so 7 bits
    typedef logic [6:0] raster_cycle_t;

    // raster line index within one frame
    // tallest frame is 312 lines, so 9 bits
    typedef logic [8:0] raster_line_t;

    // sys_clockb count inside one cpu cycle
    // 4 clocks per dot times 8 dots gives 32 states
    typedef logic [4:0] dot_phase_t;

endpackage

// ==== logic/vic_timing_top.sv ====
module vic_timing_top (
    input  logic                          sys_clockb,
    input  logic                          internal_rst,
    input  vic_timing_pkg::chip_t         chip_sel,
    output logic                          rst,
    output vic_timing_pkg::chip_t         chip,
    output logic                          dot_stb,
    output logic                          cycle_stb,
    output vic_timing_pkg::raster_cycle_t raster_cycle,
    output vic_timing_pkg::raster_line_t  raster_line,
    output logic                          frame_stb
);

    // reset, chip latch and strobes
    clockgen u_clockgen (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .chip_sel     (chip_sel),
        .rst          (rst),
        .chip         (chip),
        .dot_stb      (dot_stb),
        .cycle_stb    (cycle_stb)
    );

    // beam position, stepped once per cpu cycle
    raster_counter u_raster_counter (
        .sys_clockb   (sys_clockb),
        .rst          (rst),
        .chip         (chip),
        .cycle_stb    (cycle_stb),
        .raster_cycle (raster_cycle),
        .raster_line  (raster_line),
        .frame_stb    (frame_stb)
    );

endmodule

// ==== sim/clk_gen.sv ====
module clk_gen (
    output logic sys_clockb,
    output logic internal_rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns board clock
    initial begin
        sys_clockb = 1'b0;
        forever #10 sys_clockb = ~sys_clockb;
    end

    // power on reset, two full cycles, released on a falling edge
    initial begin
        internal_rst = 1'b1;
        repeat (2) @(posedge sys_clockb);
        @(negedge sys_clockb);
        internal_rst = 1'b0;
    end

    // raise internal_rst for a number of cycles
    // returns on the falling edge where it drops
    task automatic pulse_reset(input int unsigned cycles);
        @(negedge sys_clockb);
        internal_rst = 1'b1;
        repeat (cycles) @(negedge sys_clockb);
        internal_rst = 1'b0;
    endtask

endmodule

// ==== sim/tb_vic_timing.sv ====
`include "vic_timing_cfg.svh"

module tb_vic_timing;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned seed        = 32'h03dd_7e41;
    // cycles of pre_rst after internal_rst drops
    localparam int unsigned stretch_len = 1 << `VIC_RST_STRETCH_BITS;
    // sys_clockb cycles per cpu cycle
    localparam int unsigned cycle_len   = `VIC_DOT_DIV * `VIC_DOTS_PER_CYCLE;
    // stretch, one full cpu cycle for lock, two sync flops
    localparam int unsigned rel_latency = stretch_len + cycle_len + 2;
    // four worst case frames plus some room for the resets
    localparam longint watchdog_ns = (4 * 65 * 312 * cycle_len + 4 * 500) * 20;

    logic                          sys_clockb;
    logic                          internal_rst;
    vic_timing_pkg::chip_t         chip_sel;
    logic                          rst;
    vic_timing_pkg::chip_t         chip;
    logic                          dot_stb;
    logic                          cycle_stb;
    vic_timing_pkg::raster_cycle_t raster_cycle;
    vic_timing_pkg::raster_line_t  raster_line;
    logic                          frame_stb;

    // chip type the current run selected during reset
    vic_timing_pkg::chip_t exp_chip;

    // model state of the compare process
    logic        model_valid   = 1'b0;
    logic        rst_prev      = 1'b0;
    int unsigned m_cycle       = 0;
    int unsigned m_line        = 0;
    logic        m_frame       = 1'b0;
    logic        dot_seen      = 1'b0;
    int unsigned dot_gap       = 0;
    int unsigned dots_in_cycle = 0;
    int unsigned stb_in_frame  = 0;

    clk_gen u_clk (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst)
    );

    vic_timing_top u_dut (
        .sys_clockb   (sys_clockb),
        .internal_rst (internal_rst),
        .chip_sel     (chip_sel),
        .rst          (rst),
        .chip         (chip),
        .dot_stb      (dot_stb),
        .cycle_stb    (cycle_stb),
        .raster_cycle (raster_cycle),
        .raster_line  (raster_line),
        .frame_stb    (frame_stb)
    );

    // line length and frame height of each chip type
    function automatic void chip_geometry(
        input  vic_timing_pkg::chip_t c,
        output int unsigned           cycles_per_line,
        output int unsigned           lines_per_frame
    );
        case (c)
            vic_timing_pkg::chip_6567r56a: begin
                cycles_per_line = 64;
                lines_per_frame = 262;
            end
            vic_timing_pkg::chip_6567r8: begin
                cycles_per_line = 65;
                lines_per_frame = 263;
            end
            vic_timing_pkg::chip_6569: begin
                cycles_per_line = 63;
                lines_per_frame = 312;
            end
            default: begin
                // pal-n
                cycles_per_line = 65;
                lines_per_frame = 312;
            end
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "stopping at the first mismatch");
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: the raster did not finish its frames in the allowed time");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    // outputs sampled on the falling edge, half a cycle after they move
    always @(negedge sys_clockb) begin : compare
        int unsigned cpl;
        int unsigned lpf;
        // cpu cycles in the frame that just ended
        if (model_valid && frame_stb) begin
            chip_geometry(exp_chip, cpl, lpf);
            assert (stb_in_frame == cpl * lpf) else
                report_mismatch($sformatf("%0d cycle strobes in frame, expected %0d",
                    stb_in_frame, cpl * lpf));
            stb_in_frame = 0;
        end
        // position and frame marker against the model
        if (model_valid) begin
            assert (raster_cycle == 7'(m_cycle) && raster_line == 9'(m_line)) else
                report_mismatch($sformatf("raster at %0d/%0d, expected %0d/%0d",
                    raster_cycle, raster_line, m_cycle, m_line));
            assert (frame_stb == m_frame) else
                report_mismatch($sformatf("frame_stb %0b, expected %0b", frame_stb, m_frame));
        end
        // rising rst restarts the cadence tracking
        if (rst && !rst_prev) begin
            dot_seen      = 1'b0;
            dot_gap       = 0;
            dots_in_cycle = 0;
        end else begin
            if (dot_seen) begin
                dot_gap++;
            end
            if (dot_stb) begin
                if (dot_seen) begin
                    assert (dot_gap == `VIC_DOT_DIV) else
                        report_mismatch($sformatf("dot_stb after %0d cycles", dot_gap));
                end
                dot_seen = 1'b1;
                dot_gap  = 0;
                dots_in_cycle++;
            end else if (dot_seen) begin
                assert (dot_gap < `VIC_DOT_DIV) else
                    report_mismatch("dot_stb missing from its slot");
            end
            if (cycle_stb) begin
                assert (dot_stb) else
                    report_mismatch("cycle_stb without dot_stb");
                assert (dots_in_cycle == `VIC_DOTS_PER_CYCLE) else
                    report_mismatch($sformatf("cycle_stb after %0d dots", dots_in_cycle));
                dots_in_cycle = 0;
            end
        end
        // what the counter should show after the next edge
        if (rst) begin
            m_cycle      = 0;
            m_line       = 0;
            m_frame      = 1'b0;
            stb_in_frame = 0;
            model_valid  = 1'b1;
        end else begin
            m_frame = 1'b0;
            if (cycle_stb) begin
                chip_geometry(exp_chip, cpl, lpf);
                stb_in_frame++;
                if (m_cycle == cpl - 1) begin
                    m_cycle = 0;
                    if (m_line == lpf - 1) begin
                        m_line  = 0;
                        m_frame = 1'b1;
                    end else begin
                        m_line++;
                    end
                end else begin
                    m_cycle++;
                end
            end
        end
        rst_prev = rst;
    end

    initial begin : stimulus
        vic_timing_pkg::chip_t order [4];
        vic_timing_pkg::chip_t tmp;
        int unsigned           j;
        int unsigned           dot_first;
        logic                  exp_rst;
        logic                  exp_dot;
        logic                  exp_cyc;
        chip_sel  = vic_timing_pkg::chip_6569;
        exp_chip  = vic_timing_pkg::chip_6569;
        void'($urandom(seed));
        order[0]  = vic_timing_pkg::chip_6567r56a;
        order[1]  = vic_timing_pkg::chip_6567r8;
        order[2]  = vic_timing_pkg::chip_6569;
        order[3]  = vic_timing_pkg::chip_6572;
        // shuffle so each seed picks its own chip order
        for (int i = 3; i > 0; i--) begin
            j        = $urandom_range(i, 0);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        // first dot strobe once the phase counter runs
        dot_first = stretch_len + `VIC_DOT_DIV - 1;
        // let the power on reset finish
        repeat (3) @(negedge sys_clockb);
        for (int run = 0; run < 4; run++) begin
            u_clk.pulse_reset(2);
            // rst is up here, the new chip is latched from now on
            chip_sel = order[run];
            exp_chip = order[run];
            // falling edge k follows rising edge k after release
            for (int unsigned k = 0; k < rel_latency; k++) begin
                @(negedge sys_clockb);
                exp_rst = (k < rel_latency - 1);
                exp_dot = (k >= dot_first) && ((k - dot_first) % `VIC_DOT_DIV == 0);
                exp_cyc = (k == stretch_len + cycle_len - 1);
                assert (rst == exp_rst) else
                    report_mismatch($sformatf("rst %0b at cycle %0d of release", rst, k));
                assert (dot_stb == exp_dot && cycle_stb == exp_cyc) else
                    report_mismatch($sformatf("strobes %0b%0b at cycle %0d of release",
                        dot_stb, cycle_stb, k));
                assert (frame_stb == 1'b0) else
                    report_mismatch("frame_stb during reset");
                assert (chip == exp_chip) else
                    report_mismatch($sformatf("chip %0d, expected %0d", chip, exp_chip));
            end
            // chip_sel wanders after release, the latched chip must not
            do begin
                @(negedge sys_clockb);
                chip_sel = vic_timing_pkg::chip_t'(2'($urandom_range(3, 0)));
                assert (chip == exp_chip) else
                    report_mismatch($sformatf("chip moved to %0d, expected %0d", chip, exp_chip));
            end while (!frame_stb);
        end
        // one more edge so the compare process has checked the last frame
        @(negedge sys_clockb);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== vic_timing_top.f ====
+incdir+logic
logic/vic_timing_pkg.sv
logic/reset_stretcher.sv
logic/dot_phase_gen.sv
logic/clockgen.sv
logic/raster_counter.sv
logic/vic_timing_top.sv
sim/clk_gen.sv
sim/tb_vic_timing.sv
